//--- cacheGeomPkg.sv
`default_nettype none

package cacheGeomPkg;

  // Cache shape
  localparam int NumSets       = 16;
  localparam int WordsPerBlock = 4;
  localparam int IndexBits     = 4;
  localparam int OffsetBits    = 2;

  // Address split, byte bits at the bottom
  localparam int AddrBits = 32;
  localparam int ByteBits = 2;
  localparam int TagBits  = AddrBits - IndexBits - OffsetBits - ByteBits;

  typedef logic [31:0]           word_t;
  typedef logic [3:0]            byteMask_t;
  typedef logic [TagBits-1:0]    tag_t;
  typedef logic [IndexBits-1:0]  index_t;
  typedef logic [OffsetBits-1:0] wordOff_t;

  function automatic tag_t addrTag(input logic [AddrBits-1:0] addr);
    return addr[AddrBits-1 -: TagBits];
  endfunction

  function automatic index_t addrIndex(input logic [AddrBits-1:0] addr);
    return addr[ByteBits+OffsetBits +: IndexBits];
  endfunction

  function automatic wordOff_t addrWordOff(input logic [AddrBits-1:0] addr);
    return addr[ByteBits +: OffsetBits];
  endfunction

endpackage

`default_nettype wire

//--- cacheIfPkg.sv
`default_nettype none

package cacheIfPkg;

  // Memory-stage request from the CPU
  typedef struct packed {
    logic                   memRead;
    logic                   memWrite;
    logic [31:0]            addr;
    cacheGeomPkg::byteMask_t byteMask;
    cacheGeomPkg::word_t    writeData;
  } cpuReq_t;

  // One word beat on the memory bus
  typedef struct packed {
    logic                request;
    logic                write;
    logic [31:0]         addr;
    cacheGeomPkg::word_t writeData;
  } busReq_t;

  // Tag compare and victim choice for the current request
  typedef struct packed {
    logic                   hit;
    logic                   hitWay;
    logic                   victimWay;
    logic                   victimDirty;
    cacheGeomPkg::tag_t     victimTag;
    cacheGeomPkg::tag_t     tag;
    cacheGeomPkg::index_t   index;
    cacheGeomPkg::wordOff_t wordOff;
  } lookup_t;

  // Array write command from the controller
  typedef struct packed {
    logic                   fillWe;
    logic                   cpuWe;
    logic                   way;
    cacheGeomPkg::wordOff_t arrWordOff;
    logic                   tagWe;
    logic                   touch;
  } arrayCtrl_t;

  // Both ways of one set, plus its LRU bit
  typedef struct packed {
    logic [1:0]                    valid;
    logic [1:0]                    dirty;
    cacheGeomPkg::tag_t [1:0]      tag;
    logic                          lru;
  } setState_t;

endpackage

`default_nettype wire

//--- dcacheLookup.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheLookup (
  input  cacheIfPkg::cpuReq_t   cpuReq,
  input  cacheIfPkg::setState_t setState,
  output cacheIfPkg::lookup_t   lookup
);

  import cacheGeomPkg::*;

  tag_t       reqTag;
  logic [1:0] wayHit;
  logic       victim;

  assign reqTag = addrTag(cpuReq.addr);

  // Tag match per way, only on valid lines
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayHit[w] = setState.valid[w] && (setState.tag[w] == reqTag);
    end
  end

  // Invalid way first, then the LRU way
  always_comb begin
    if (!setState.valid[0]) begin
      victim = 1'b0;
    end else if (!setState.valid[1]) begin
      victim = 1'b1;
    end else begin
      victim = setState.lru;
    end
  end

  always_comb begin
    lookup.hit         = |wayHit;
    lookup.hitWay      = wayHit[1];
    lookup.victimWay   = victim;
    // An invalid victim never needs a write-back
    lookup.victimDirty = setState.valid[victim] && setState.dirty[victim];
    lookup.victimTag   = setState.tag[victim];
    lookup.tag         = reqTag;
    lookup.index       = addrIndex(cpuReq.addr);
    lookup.wordOff     = addrWordOff(cpuReq.addr);
  end

endmodule

`default_nettype wire

//--- dcacheController.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheController (
  input  logic                   clk,
  input  logic                   reset,
  input  cacheIfPkg::cpuReq_t    cpuReq,
  input  cacheIfPkg::lookup_t    lookup,
  input  logic                   BusReady,
  output cacheIfPkg::busReq_t    busReq,
  output cacheIfPkg::arrayCtrl_t arrayCtrl,
  output logic                   Stall,
  input  cacheGeomPkg::word_t    victimData
);

  import cacheGeomPkg::*;

  typedef enum logic [2:0] {
    Ready,
    WriteBack,
    LastWriteBack,
    MemRead,
    LastRead,
    NextReq
  } cacheState_t;

  cacheState_t state;
  cacheState_t nextState;
  wordOff_t    beatCount;
  logic        access;
  logic        miss;
  logic        lastBeat;

  assign access   = cpuReq.memRead || cpuReq.memWrite;
  assign miss     = access && !lookup.hit;
  assign lastBeat = BusReady && (beatCount == wordOff_t'(WordsPerBlock - 1));

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= Ready;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      Ready: begin
        if (miss) begin
          nextState = lookup.victimDirty ? WriteBack : MemRead;
        end
      end
      WriteBack: begin
        if (lastBeat) begin
          nextState = LastWriteBack;
        end
      end
      LastWriteBack: nextState = MemRead;
      MemRead: begin
        if (lastBeat) begin
          nextState = LastRead;
        end
      end
      LastRead: nextState = NextReq;
      // One spare cycle so the lookup sees the new tag
      NextReq: nextState = Ready;
      default: nextState = Ready;
    endcase
  end

  // Burst word counter, wraps from the last write-back beat into the fill
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      beatCount <= '0;
    end else if (nextState == Ready) begin
      beatCount <= '0;
    end else if (busReq.request && BusReady) begin
      beatCount <= beatCount + 1'b1;
    end
  end

  // Bus beats
  always_comb begin
    busReq.request   = (state == WriteBack) || (state == MemRead);
    busReq.write     = (state == WriteBack);
    busReq.writeData = victimData;
    if (state == WriteBack) begin
      busReq.addr = {lookup.victimTag, lookup.index, beatCount, {ByteBits{1'b0}}};
    end else begin
      busReq.addr = {lookup.tag, lookup.index, beatCount, {ByteBits{1'b0}}};
    end
  end

  // Array commands
  always_comb begin
    arrayCtrl.fillWe = (state == MemRead) && BusReady;
    arrayCtrl.tagWe  = (state == MemRead) && lastBeat;
    arrayCtrl.cpuWe  = (state == Ready) && cpuReq.memWrite && lookup.hit;
    arrayCtrl.touch  = (state == Ready) && access && lookup.hit;
    // Hit way while serving, victim way during bursts
    if (state == Ready) begin
      arrayCtrl.way        = lookup.hitWay;
      arrayCtrl.arrWordOff = lookup.wordOff;
    end else begin
      arrayCtrl.way        = lookup.victimWay;
      arrayCtrl.arrWordOff = beatCount;
    end
  end

  assign Stall = (state != Ready) || miss;

endmodule

`default_nettype wire

//--- dcacheArrays.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheArrays (
  input  logic                   clk,
  input  logic                   reset,
  input  cacheGeomPkg::index_t   index,
  input  cacheGeomPkg::wordOff_t wordOff,
  input  cacheIfPkg::arrayCtrl_t arrayCtrl,
  input  cacheIfPkg::cpuReq_t    cpuReq,
  input  cacheGeomPkg::word_t    busRdata,
  output cacheIfPkg::setState_t  setState,
  output cacheGeomPkg::word_t    readData,
  output cacheGeomPkg::word_t    victimData
);

  import cacheGeomPkg::*;

  tag_t               tagMem [2][NumSets];
  logic [NumSets-1:0] validBits [2];
  logic [NumSets-1:0] dirtyBits [2];
  logic [NumSets-1:0] lruBits;
  word_t              dataMem [2][NumSets][WordsPerBlock];

  // Set readout for the lookup block
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      setState.valid[w] = validBits[w][index];
      setState.dirty[w] = dirtyBits[w][index];
      setState.tag[w]   = tagMem[w][index];
    end
    setState.lru = lruBits[index];
  end

  // Hit word for the CPU, burst word for the write-back
  assign readData   = dataMem[arrayCtrl.way][index][wordOff];
  assign victimData = dataMem[arrayCtrl.way][index][arrayCtrl.arrWordOff];

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      validBits[0] <= '0;
      validBits[1] <= '0;
      dirtyBits[0] <= '0;
      dirtyBits[1] <= '0;
      lruBits      <= '0;
    end else begin
      // New line arrives clean
      if (arrayCtrl.tagWe) begin
        validBits[arrayCtrl.way][index] <= 1'b1;
        dirtyBits[arrayCtrl.way][index] <= 1'b0;
      end
      if (arrayCtrl.cpuWe) begin
        dirtyBits[arrayCtrl.way][index] <= 1'b1;
      end
      // LRU names the way not just used
      if (arrayCtrl.touch) begin
        lruBits[index] <= ~arrayCtrl.way;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (arrayCtrl.tagWe) begin
      tagMem[arrayCtrl.way][index] <= addrTag(cpuReq.addr);
    end
  end

  // Fill word or byte-merged CPU store
  always_ff @(posedge clk) begin
    if (arrayCtrl.fillWe) begin
      dataMem[arrayCtrl.way][index][arrayCtrl.arrWordOff] <= busRdata;
    end else if (arrayCtrl.cpuWe) begin
      for (int b = 0; b < 4; b++) begin
        if (cpuReq.byteMask[b]) begin
          dataMem[arrayCtrl.way][index][arrayCtrl.arrWordOff][8*b +: 8] <=
            cpuReq.writeData[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- dcacheTop.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheTop (
  input  logic                clk,
  input  logic                reset,
  input  cacheIfPkg::cpuReq_t cpuReq,
  output cacheGeomPkg::word_t readData,
  output logic                Stall,
  output cacheIfPkg::busReq_t busReq,
  input  cacheGeomPkg::word_t busRdata,
  input  logic                BusReady
);

  import cacheGeomPkg::*;
  import cacheIfPkg::*;

  lookup_t    lookup;
  setState_t  setState;
  arrayCtrl_t arrayCtrl;
  word_t      victimData;

  dcacheLookup lookupBlock (
    .cpuReq   (cpuReq),
    .setState (setState),
    .lookup   (lookup)
  );

  dcacheController controller (
    .clk        (clk),
    .reset      (reset),
    .cpuReq     (cpuReq),
    .lookup     (lookup),
    .BusReady   (BusReady),
    .busReq     (busReq),
    .arrayCtrl  (arrayCtrl),
    .Stall      (Stall),
    .victimData (victimData)
  );

  // Set index straight from the address keeps the set readout off the lookup path
  dcacheArrays arrays (
    .clk        (clk),
    .reset      (reset),
    .index      (addrIndex(cpuReq.addr)),
    .wordOff    (addrWordOff(cpuReq.addr)),
    .arrayCtrl  (arrayCtrl),
    .cpuReq     (cpuReq),
    .busRdata   (busRdata),
    .setState   (setState),
    .readData   (readData),
    .victimData (victimData)
  );

endmodule

`default_nettype wire

//--- dcacheTop_props.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheTopProps (
  input logic                clk,
  input logic                reset,
  input cacheIfPkg::busReq_t busReq,
  input logic                BusReady,
  input logic                Stall
);

  // Beat held until the bus takes it
  beatHeld: assert property (@(posedge clk) disable iff (reset)
    busReq.request && !BusReady |=> $stable(busReq))
    else $error("bus beat changed while BusReady was low");

  // CPU stays held in the cycle after every beat, so a burst never ends straight in Ready
  stallAfterBeat: assert property (@(posedge clk) disable iff (reset)
    busReq.request |=> Stall)
    else $error("Stall low in the cycle after a bus beat");

  // Fill never turns back into a write-back
  fillReadOnly: assert property (@(posedge clk) disable iff (reset)
    busReq.request && !busReq.write |=> !(busReq.request && busReq.write))
    else $error("write beat during a fill");

endmodule

bind dcacheTop dcacheTopProps props (
  .clk      (clk),
  .reset    (reset),
  .busReq   (busReq),
  .BusReady (BusReady),
  .Stall    (Stall)
);

`default_nettype wire

//--- dcacheTb.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheTb;

  import cacheGeomPkg::*;
  import cacheIfPkg::*;

  localparam int NumRows       = 20;
  localparam int TimeoutCycles = NumRows * 40;
  localparam int MemWords      = 4096;

  typedef struct packed {
    logic        write;
    logic [31:0] addr;
    byteMask_t   mask;
    word_t       data;
    logic        expectMiss;
  } row_t;

  logic    clk;
  logic    reset;
  cpuReq_t cpuReq;
  word_t   readData;
  logic    Stall;
  busReq_t busReq;
  word_t   busRdata;
  logic    BusReady;

  row_t   rows [NumRows];
  word_t  busMem [MemWords];
  word_t  refMem [MemWords];
  integer seed = 32'h85cc;
  int     readBeats;
  int     writeBeats;
  int     errors = 0;
  int     cycles = 0;

  // Two-way tag model of the cache
  logic [23:0] modelTag [NumSets][2];
  logic        modelValid [NumSets][2];
  logic        modelDirty [NumSets][2];
  logic        modelLru [NumSets];

  dcacheTop DUT (
    .clk      (clk),
    .reset    (reset),
    .cpuReq   (cpuReq),
    .readData (readData),
    .Stall    (Stall),
    .busReq   (busReq),
    .busRdata (busRdata),
    .BusReady (BusReady)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // Odd multiplier keeps every word of memory distinct
  function automatic word_t initWord(input int idx);
    return (idx * 32'h9e3779b1) ^ 32'h0badf00d;
  endfunction

  function automatic int wordIndex(input logic [31:0] addr);
    return int'(addr[13:2]);
  endfunction

  function automatic word_t mergeBytes(input word_t old, input word_t data, input byteMask_t mask);
    word_t result;
    result = old;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        result[8*b +: 8] = data[8*b +: 8];
      end
    end
    return result;
  endfunction

  function automatic row_t makeRow(input logic write, input logic [31:0] addr,
                                   input byteMask_t mask, input word_t data, input logic miss);
    return '{write: write, addr: addr, mask: mask, data: data, expectMiss: miss};
  endfunction

  task automatic reportError(input string msg);
    $display("** Error @ %0t: %s", $time, msg);
    errors++;
  endtask

  // Set 0 holds A 0x100, B 0x500, C 0x900; set 4 holds D 0x040
  task automatic loadRows();
    rows[0]  = makeRow(1'b0, 32'h100, 4'h0, 32'h0, 1'b1);
    rows[1]  = makeRow(1'b0, 32'h104, 4'h0, 32'h0, 1'b0);
    rows[2]  = makeRow(1'b0, 32'h108, 4'h0, 32'h0, 1'b0);
    rows[3]  = makeRow(1'b0, 32'h10c, 4'h0, 32'h0, 1'b0);
    rows[4]  = makeRow(1'b1, 32'h104, 4'b0011, 32'hdeadbeef, 1'b0);
    rows[5]  = makeRow(1'b0, 32'h104, 4'h0, 32'h0, 1'b0);
    rows[6]  = makeRow(1'b0, 32'h500, 4'h0, 32'h0, 1'b1);
    rows[7]  = makeRow(1'b0, 32'h100, 4'h0, 32'h0, 1'b0);
    rows[8]  = makeRow(1'b0, 32'h900, 4'h0, 32'h0, 1'b1);
    rows[9]  = makeRow(1'b0, 32'h108, 4'h0, 32'h0, 1'b0);
    rows[10] = makeRow(1'b0, 32'h500, 4'h0, 32'h0, 1'b1);
    rows[11] = makeRow(1'b1, 32'h50c, 4'b1100, 32'h12345678, 1'b0);
    rows[12] = makeRow(1'b0, 32'h900, 4'h0, 32'h0, 1'b1);
    rows[13] = makeRow(1'b0, 32'h104, 4'h0, 32'h0, 1'b1);
    rows[14] = makeRow(1'b1, 32'h040, 4'b1111, 32'hcafef00d, 1'b1);
    rows[15] = makeRow(1'b0, 32'h040, 4'h0, 32'h0, 1'b0);
    rows[16] = makeRow(1'b1, 32'h04c, 4'b0100, 32'h00a50000, 1'b0);
    rows[17] = makeRow(1'b0, 32'h100, 4'h0, 32'h0, 1'b0);
    rows[18] = makeRow(1'b0, 32'h50c, 4'h0, 32'h0, 1'b1);
    rows[19] = makeRow(1'b0, 32'h04c, 4'h0, 32'h0, 1'b0);
  endtask

  // Invalid way first, else LRU; the used way becomes most recent
  task automatic modelAccess(input row_t row, output logic miss, output logic victimDirty);
    logic [3:0]  set;
    logic [23:0] tag;
    logic        way;
    set = row.addr[7:4];
    tag = row.addr[31:8];
    miss = 1'b1;
    victimDirty = 1'b0;
    if (!modelValid[set][0]) begin
      way = 1'b0;
    end else if (!modelValid[set][1]) begin
      way = 1'b1;
    end else begin
      way = modelLru[set];
    end
    for (int w = 0; w < 2; w++) begin
      if (modelValid[set][w] && modelTag[set][w] == tag) begin
        miss = 1'b0;
        way = w[0];
      end
    end
    if (miss) begin
      victimDirty = modelValid[set][way] && modelDirty[set][way];
      modelValid[set][way] = 1'b1;
      modelTag[set][way] = tag;
      modelDirty[set][way] = 1'b0;
    end
    if (row.write) begin
      modelDirty[set][way] = 1'b1;
    end
    modelLru[set] = ~way;
  endtask

  // Bus memory with a random wait before each beat
  initial begin
    int waitLeft;
    int idx;
    BusReady = 1'b0;
    busRdata = '0;
    waitLeft = -1;
    forever begin
      @(posedge clk);
      #1;
      BusReady = 1'b0;
      if (!reset && busReq.request) begin
        if (waitLeft < 0) begin
          waitLeft = $unsigned($random(seed)) % 4;
        end
        if (waitLeft == 0) begin
          BusReady = 1'b1;
          idx = wordIndex(busReq.addr);
          if (busReq.write) begin
            assert (busReq.addr[3:2] == writeBeats[1:0])
              else reportError($sformatf("write-back beat at %h out of order", busReq.addr));
            assert (busReq.writeData == refMem[idx])
              else reportError($sformatf("write-back to %h gave %h, expected %h",
                                         busReq.addr, busReq.writeData, refMem[idx]));
            busMem[idx] = busReq.writeData;
            writeBeats++;
          end else begin
            assert (busReq.addr[31:4] == cpuReq.addr[31:4] && busReq.addr[3:2] == readBeats[1:0])
              else reportError($sformatf("fill beat at %h, request %h", busReq.addr, cpuReq.addr));
            busRdata = busMem[idx];
            readBeats++;
          end
        end
        waitLeft--;
      end
    end
  end

  initial begin
    logic missSeen;
    logic expMiss;
    logic expDirty;
    int   idx;
    int   errsBefore;
    int   passed;
    passed = 0;
    reset = 1'b1;
    cpuReq = '0;
    loadRows();
    for (int i = 0; i < MemWords; i++) begin
      busMem[i] = initWord(i);
      refMem[i] = initWord(i);
    end
    for (int s = 0; s < NumSets; s++) begin
      modelValid[s] = '{1'b0, 1'b0};
      modelDirty[s] = '{1'b0, 1'b0};
      modelLru[s] = 1'b0;
    end
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < NumRows; i++) begin
      @(posedge clk);
      #1;
      cpuReq = '{memRead: !rows[i].write, memWrite: rows[i].write, addr: rows[i].addr,
                 byteMask: rows[i].mask, writeData: rows[i].data};
      readBeats = 0;
      writeBeats = 0;
      errsBefore = errors;
      idx = wordIndex(rows[i].addr);
      modelAccess(rows[i], expMiss, expDirty);
      @(negedge clk);
      missSeen = Stall;
      while (Stall) begin
        @(negedge clk);
      end
      assert (rows[i].expectMiss == expMiss)
        else reportError($sformatf("row %0d miss flag disagrees with the LRU model", i));
      assert (missSeen == expMiss)
        else reportError($sformatf("Stall in first cycle was %b, expected %b", missSeen, expMiss));
      assert (readBeats == (expMiss ? 4 : 0))
        else reportError($sformatf("%0d fill beats, expected %0d", readBeats, expMiss ? 4 : 0));
      assert (writeBeats == (expDirty ? 4 : 0))
        else reportError($sformatf("%0d write-back beats, expected %0d",
                                   writeBeats, expDirty ? 4 : 0));
      if (rows[i].write) begin
        refMem[idx] = mergeBytes(refMem[idx], rows[i].data, rows[i].mask);
      end else begin
        assert (readData == refMem[idx])
          else reportError($sformatf("read %h gave %h, expected %h",
                                     rows[i].addr, readData, refMem[idx]));
      end
      if (errors == errsBefore) begin
        passed++;
      end
      $display("Row %0d %s %h miss=%b: %s", i, rows[i].write ? "write" : "read",
               rows[i].addr, expMiss, (errors == errsBefore) ? "ok" : "failed");
    end
    @(posedge clk);
    #1;
    cpuReq = '0;
    $display("Rows passed %0d, failed %0d, errors %0d", passed, NumRows - passed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dcache.f
cacheGeomPkg.sv
cacheIfPkg.sv
dcacheLookup.sv
dcacheController.sv
dcacheArrays.sv
dcacheTop.sv
dcacheTop_props.sv
dcacheTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dcacheTb
FILELIST  ?= dcache.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "STATUS: FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
